/* common/axi4s_pkg.sv */
// -------------------------------------------------------------------------
// Shared widths, mode encoding and beat layout for the AXI-S FIFO
// Field widths are fixed here; every stream port is sized from them
// All sideband fields are always carried, none are optional
// -------------------------------------------------------------------------

package axi4s_pkg;

    // -----------------------------------------------------------------------
    // Stream field widths
    // -----------------------------------------------------------------------
    // Data bus width in bytes
    localparam int DATA_BYTE_WID = 8;
    localparam int DATA_WID      = DATA_BYTE_WID * 8;

    // Sideband widths
    localparam int TID_WID   = 4;
    localparam int TDEST_WID = 4;
    localparam int TUSER_WID = 8;

    // -----------------------------------------------------------------------
    // Optimization mode
    // -----------------------------------------------------------------------
    // Timing mode registers the RAM read, latency mode reads it directly
    typedef enum logic {
        OPT_MODE_TIMING  = 1'b0,
        OPT_MODE_LATENCY = 1'b1
    } opt_mode_t;

    // -----------------------------------------------------------------------
    // Stored beat
    // -----------------------------------------------------------------------
    // One FIFO word holds every field of one transfer
    typedef struct packed {
        logic [DATA_WID-1:0]      tdata;
        logic [DATA_BYTE_WID-1:0] tkeep;
        logic                     tlast;
        logic [TID_WID-1:0]       tid;
        logic [TDEST_WID-1:0]     tdest;
        logic [TUSER_WID-1:0]     tuser;
    } axi4s_beat_t;

    // 64 + 8 + 1 + 4 + 4 + 8 bits
    localparam int BEAT_WID = $bits(axi4s_beat_t);

endpackage : axi4s_pkg

/* fifo/fifo_ctrl.sv */
// -------------------------------------------------------------------------
// Pointer and occupancy control for the synchronous FIFO
// DEPTH must be a power of two, 4 or more; pointers wrap on their own
// Total occupancy covers RAM, a read in flight and the output register
// -------------------------------------------------------------------------
`timescale 1ns/100ps

module fifo_ctrl
    import axi4s_pkg::*;
#(
    parameter int        DEPTH         = 32,
    parameter opt_mode_t FIFO_OPT_MODE = OPT_MODE_TIMING
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     push_req,
    input  logic                     pop,
    input  logic                     ram_valid,
    input  logic                     out_room,
    output logic                     in_ready,
    output logic                     wr_en,
    output logic [$clog2(DEPTH)-1:0] wr_addr,
    output logic                     rd_en,
    output logic [$clog2(DEPTH)-1:0] rd_addr
);

    localparam int             AW      = $clog2(DEPTH);
    localparam logic [AW:0]    DEPTH_L = (AW+1)'(DEPTH);

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   ram_cnt;
    logic [AW:0]   total;
    logic          rd_inflight;
    logic          rd_block;

    // -----------------------------------------------------------------------
    // Handshake decode
    // -----------------------------------------------------------------------
    // Room is judged on the registered total, so ready rises a cycle after pop
    assign in_ready = (total < DEPTH_L);
    assign wr_en    = push_req && in_ready;

    // Timing mode waits for the pending read to land before the next one
    assign rd_block = (FIFO_OPT_MODE == OPT_MODE_TIMING) ? rd_inflight : 1'b0;
    assign rd_en    = (ram_cnt != '0) && out_room && !rd_block;

    assign wr_addr  = wr_ptr;
    assign rd_addr  = rd_ptr;

    // -----------------------------------------------------------------------
    // Pointers and counts
    // -----------------------------------------------------------------------
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            ram_cnt     <= '0;
            total       <= '0;
            rd_inflight <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;

            // Beats resident in the RAM only
            case ({wr_en, rd_en})
                2'b10:   ram_cnt <= ram_cnt + 1'b1;
                2'b01:   ram_cnt <= ram_cnt - 1'b1;
                default: ram_cnt <= ram_cnt;
            endcase

            // Everything held anywhere in the subsystem
            case ({wr_en, pop})
                2'b10:   total <= total + 1'b1;
                2'b01:   total <= total - 1'b1;
                default: total <= total;
            endcase

            // Set by the read, cleared when the data reaches the output stage
            if (ram_valid)  rd_inflight <= 1'b0;
            else if (rd_en) rd_inflight <= 1'b1;
        end
    end

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------
    // A write never lands on an unread RAM word
    a_no_wr_full : assert property (@(posedge aclk) disable iff (!rst_n)
        wr_en |-> (ram_cnt < DEPTH_L));

    a_total_bound : assert property (@(posedge aclk) disable iff (!rst_n)
        total <= DEPTH_L);

    // Output handshake needs a beat somewhere in the FIFO
    a_no_pop_empty : assert property (@(posedge aclk) disable iff (!rst_n)
        (total == '0) |-> !pop);

endmodule : fifo_ctrl

/* fifo/fifo_ram.sv */
// -------------------------------------------------------------------------
// Simple dual-port storage, one write and one read port
// Read data is registered when REG_READ is set, otherwise combinational
// No reset; contents are undefined until written
// -------------------------------------------------------------------------
`timescale 1ns/100ps

module fifo_ram #(
    parameter int  DEPTH    = 32,
    parameter type DATA_T   = logic [7:0],
    parameter bit  REG_READ = 1'b1
) (
    input  logic                     aclk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  DATA_T                    wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output DATA_T                    rd_data
);

    // Storage array
    DATA_T mem [DEPTH];

    // Write port
    always_ff @(posedge aclk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // Read port
    generate
        if (REG_READ) begin : g_reg_read
            // Data valid the cycle after rd_en
            always_ff @(posedge aclk) begin
                if (rd_en) rd_data <= mem[rd_addr];
            end
        end else begin : g_comb_read
            // Same-cycle read, caller qualifies with rd_en
            assign rd_data = mem[rd_addr];
        end
    endgenerate

endmodule : fifo_ram

/* fifo/axi4s_fifo_core.sv */
// -------------------------------------------------------------------------
// Word-based AXI-S FIFO core, single clock
// Not packet-aware; every beat passes through unchanged and in order
// Output stage is one register fed by the RAM read port
// -------------------------------------------------------------------------
`timescale 1ns/100ps

module axi4s_fifo_core
    import axi4s_pkg::*;
#(
    parameter int        DEPTH         = 32,
    parameter opt_mode_t FIFO_OPT_MODE = OPT_MODE_TIMING
) (
    input  logic                     aclk,
    input  logic                     rst_n,

    // AXI-S input side
    input  logic                     in_tvalid,
    output logic                     in_tready,
    input  logic [DATA_WID-1:0]      in_tdata,
    input  logic [DATA_BYTE_WID-1:0] in_tkeep,
    input  logic                     in_tlast,
    input  logic [TID_WID-1:0]       in_tid,
    input  logic [TDEST_WID-1:0]     in_tdest,
    input  logic [TUSER_WID-1:0]     in_tuser,

    // AXI-S output side
    output logic                     out_tvalid,
    input  logic                     out_tready,
    output logic [DATA_WID-1:0]      out_tdata,
    output logic [DATA_BYTE_WID-1:0] out_tkeep,
    output logic                     out_tlast,
    output logic [TID_WID-1:0]       out_tid,
    output logic [TDEST_WID-1:0]     out_tdest,
    output logic [TUSER_WID-1:0]     out_tuser
);

    localparam int AW = $clog2(DEPTH);

    axi4s_beat_t   in_beat;
    axi4s_beat_t   rd_data;
    axi4s_beat_t   out_beat;
    logic          out_valid;
    logic          out_room;
    logic          pop;
    logic          ram_valid;
    logic          rd_pend;
    logic          wr_en;
    logic          rd_en;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    // -----------------------------------------------------------------------
    // Beat packing
    // -----------------------------------------------------------------------
    assign in_beat.tdata = in_tdata;
    assign in_beat.tkeep = in_tkeep;
    assign in_beat.tlast = in_tlast;
    assign in_beat.tid   = in_tid;
    assign in_beat.tdest = in_tdest;
    assign in_beat.tuser = in_tuser;

    // -----------------------------------------------------------------------
    // Pointer control and storage
    // -----------------------------------------------------------------------
    fifo_ctrl #(
        .DEPTH         ( DEPTH ),
        .FIFO_OPT_MODE ( FIFO_OPT_MODE )
    ) i_fifo_ctrl (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .push_req  ( in_tvalid ),
        .pop       ( pop ),
        .ram_valid ( ram_valid ),
        .out_room  ( out_room ),
        .in_ready  ( in_tready ),
        .wr_en     ( wr_en ),
        .wr_addr   ( wr_addr ),
        .rd_en     ( rd_en ),
        .rd_addr   ( rd_addr )
    );

    fifo_ram #(
        .DEPTH    ( DEPTH ),
        .DATA_T   ( axi4s_beat_t ),
        .REG_READ ( FIFO_OPT_MODE == OPT_MODE_TIMING )
    ) i_fifo_ram (
        .aclk    ( aclk ),
        .wr_en   ( wr_en ),
        .wr_addr ( wr_addr ),
        .wr_data ( in_beat ),
        .rd_en   ( rd_en ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data )
    );

    // Read data lands one cycle late when the RAM output is registered
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) rd_pend <= 1'b0;
        else        rd_pend <= rd_en;
    end

    assign ram_valid = (FIFO_OPT_MODE == OPT_MODE_TIMING) ? rd_pend : rd_en;

    // -----------------------------------------------------------------------
    // Output register
    // -----------------------------------------------------------------------
    // Empty, or draining this cycle
    assign out_room = !out_valid || out_tready;
    assign pop      = out_valid && out_tready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n)         out_valid <= 1'b0;
        else if (ram_valid) out_valid <= 1'b1;
        else if (pop)       out_valid <= 1'b0;
    end

    // Payload only, no reset
    always_ff @(posedge aclk) begin
        if (ram_valid) out_beat <= rd_data;
    end

    // Unpack
    assign out_tvalid = out_valid;
    assign out_tdata  = out_beat.tdata;
    assign out_tkeep  = out_beat.tkeep;
    assign out_tlast  = out_beat.tlast;
    assign out_tid    = out_beat.tid;
    assign out_tdest  = out_beat.tdest;
    assign out_tuser  = out_beat.tuser;

    // Stalled beat must hold until taken
    a_out_stable : assert property (@(posedge aclk) disable iff (!rst_n)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_beat)));

endmodule : axi4s_fifo_core

/* hdl/axi4s_fifo_sync.sv */
// -------------------------------------------------------------------------
// Synchronous word-based AXI-S FIFO, top level
// Single clock aclk; not packet-aware, beats leave in arrival order
// DEPTH must be a power of two, 4 or more
// -------------------------------------------------------------------------
`timescale 1ns/100ps

module axi4s_fifo_sync
    import axi4s_pkg::*;
#(
    parameter int        DEPTH         = 32,
    parameter opt_mode_t FIFO_OPT_MODE = OPT_MODE_TIMING
) (
    input  logic                     aclk,
    input  logic                     rst_n,

    // Write side
    input  logic                     in_tvalid,
    output logic                     in_tready,
    input  logic [DATA_WID-1:0]      in_tdata,
    input  logic [DATA_BYTE_WID-1:0] in_tkeep,
    input  logic                     in_tlast,
    input  logic [TID_WID-1:0]       in_tid,
    input  logic [TDEST_WID-1:0]     in_tdest,
    input  logic [TUSER_WID-1:0]     in_tuser,

    // Read side
    output logic                     out_tvalid,
    input  logic                     out_tready,
    output logic [DATA_WID-1:0]      out_tdata,
    output logic [DATA_BYTE_WID-1:0] out_tkeep,
    output logic                     out_tlast,
    output logic [TID_WID-1:0]       out_tid,
    output logic [TDEST_WID-1:0]     out_tdest,
    output logic [TUSER_WID-1:0]     out_tuser
);

    // Core in single-clock configuration
    axi4s_fifo_core #(
        .DEPTH         ( DEPTH ),
        .FIFO_OPT_MODE ( FIFO_OPT_MODE )
    ) i_axi4s_fifo_core (
        .aclk       ( aclk ),
        .rst_n      ( rst_n ),
        .in_tvalid  ( in_tvalid ),
        .in_tready  ( in_tready ),
        .in_tdata   ( in_tdata ),
        .in_tkeep   ( in_tkeep ),
        .in_tlast   ( in_tlast ),
        .in_tid     ( in_tid ),
        .in_tdest   ( in_tdest ),
        .in_tuser   ( in_tuser ),
        .out_tvalid ( out_tvalid ),
        .out_tready ( out_tready ),
        .out_tdata  ( out_tdata ),
        .out_tkeep  ( out_tkeep ),
        .out_tlast  ( out_tlast ),
        .out_tid    ( out_tid ),
        .out_tdest  ( out_tdest ),
        .out_tuser  ( out_tuser )
    );

endmodule : axi4s_fifo_sync

/* sim/tb_axi4s_fifo_sync.sv */
// ---------------------------------------------------------------------------
// Testbench for the synchronous AXI-S FIFO at DEPTH 32
// FIFO_OPT_MODE 0 runs timing mode, 1 runs latency mode
// Checks are concurrent assertions; the first failure ends the run
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_axi4s_fifo_sync
    import axi4s_pkg::*;
#(
    parameter int FIFO_OPT_MODE = 0
);

    localparam int        DEPTH     = 32;
    localparam int        NUM_BEATS = 2000;
    localparam opt_mode_t MODE      = opt_mode_t'(FIFO_OPT_MODE[0]);
    // Edges from input acceptance to out_tvalid, empty FIFO
    localparam int        FIRST_LAT = (MODE == OPT_MODE_LATENCY) ? 2 : 3;

    logic                     aclk;
    logic                     rst_n;
    logic                     in_tvalid;
    logic                     in_tready;
    logic [DATA_WID-1:0]      in_tdata;
    logic [DATA_BYTE_WID-1:0] in_tkeep;
    logic                     in_tlast;
    logic [TID_WID-1:0]       in_tid;
    logic [TDEST_WID-1:0]     in_tdest;
    logic [TUSER_WID-1:0]     in_tuser;
    logic                     out_tvalid;
    logic                     out_tready;
    logic [DATA_WID-1:0]      out_tdata;
    logic [DATA_BYTE_WID-1:0] out_tkeep;
    logic                     out_tlast;
    logic [TID_WID-1:0]       out_tid;
    logic [TDEST_WID-1:0]     out_tdest;
    logic [TUSER_WID-1:0]     out_tuser;

    // Reference model and phase flags
    logic [31:0] rng         = 32'h2f26_5019;
    string       test_name   = "reset";
    axi4s_beat_t exp_q[$];
    axi4s_beat_t exp_head    = '0;
    axi4s_beat_t in_beat;
    axi4s_beat_t act_beat;
    int          exp_count   = 0;
    int          fill_cnt    = 0;
    int          lat_cnt     = 0;
    logic        in_fire_q   = 1'b0;
    logic        out_fire_q  = 1'b0;
    logic        reset_tail  = 1'b1;
    logic        fill_phase  = 1'b0;
    logic        pop_phase   = 1'b0;
    logic        lat_phase   = 1'b0;
    logic        drain_phase = 1'b0;

    // Same field order as the packed beat
    assign in_beat  = {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest, in_tuser};
    assign act_beat = {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest, out_tuser};

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    axi4s_fifo_sync #(
        .DEPTH         ( DEPTH ),
        .FIFO_OPT_MODE ( MODE )
    ) i_dut (
        .aclk       ( aclk ),
        .rst_n      ( rst_n ),
        .in_tvalid  ( in_tvalid ),
        .in_tready  ( in_tready ),
        .in_tdata   ( in_tdata ),
        .in_tkeep   ( in_tkeep ),
        .in_tlast   ( in_tlast ),
        .in_tid     ( in_tid ),
        .in_tdest   ( in_tdest ),
        .in_tuser   ( in_tuser ),
        .out_tvalid ( out_tvalid ),
        .out_tready ( out_tready ),
        .out_tdata  ( out_tdata ),
        .out_tkeep  ( out_tkeep ),
        .out_tlast  ( out_tlast ),
        .out_tid    ( out_tid ),
        .out_tdest  ( out_tdest ),
        .out_tuser  ( out_tuser )
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic drive_random_beat();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] side;
        hi        = next_rand();
        lo        = next_rand();
        side      = next_rand();
        in_tdata  = {hi, lo};
        in_tkeep  = side[7:0];
        in_tlast  = side[8];
        in_tid    = side[12:9];
        in_tdest  = side[16:13];
        in_tuser  = side[24:17];
    endtask

    // All waits return 1 ns after the edge that ends them
    task automatic wait_in_accept(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge aclk);
            #1;
            n++;
            if (n > limit) fail_and_stop("timeout waiting for an input handshake");
        end while (!in_fire_q);
    endtask

    task automatic wait_out_accept(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge aclk);
            #1;
            n++;
            if (n > limit) fail_and_stop("timeout waiting for an output handshake");
        end while (!out_fire_q);
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge aclk);
            #1;
            n++;
            if (n > limit) fail_and_stop("timeout waiting for the FIFO to drain");
        end while (exp_count != 0 || out_tvalid);
    endtask

    // ------------------------------------------------------------------------
    // Reference queue and cycle bookkeeping
    // ------------------------------------------------------------------------
    always @(posedge aclk) begin
        if (rst_n) begin
            if (in_tvalid && in_tready) exp_q.push_back(in_beat);
            if (out_tvalid && out_tready && exp_q.size() != 0) void'(exp_q.pop_front());
        end
        exp_head   <= (exp_q.size() != 0) ? exp_q[0] : '0;
        exp_count  <= exp_q.size();
        in_fire_q  <= rst_n && in_tvalid && in_tready;
        out_fire_q <= rst_n && out_tvalid && out_tready;
        reset_tail <= !rst_n;
        fill_cnt   <= fill_phase ? fill_cnt + int'(in_tvalid && in_tready) : 0;
        // Edges since the single beat was accepted
        if (!lat_phase)                   lat_cnt <= 0;
        else if (in_tvalid && in_tready)  lat_cnt <= 1;
        else if (lat_cnt != 0 && lat_cnt < 15) lat_cnt <= lat_cnt + 1;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_reset_state : assert property (@(posedge aclk)
        (!rst_n || reset_tail) |-> (!out_tvalid && in_tready))
        else fail_and_stop("reset state wrong, out_tvalid high or in_tready low");

    a_data_match : assert property (@(posedge aclk) disable iff (!rst_n)
        (out_tvalid && out_tready && exp_count != 0) |-> (act_beat == exp_head))
        else fail_and_stop($sformatf("mismatch %s expected %h actual %h",
            test_name, $sampled(exp_head), $sampled(act_beat)));

    a_no_extra : assert property (@(posedge aclk) disable iff (!rst_n)
        (out_tvalid && out_tready) |-> (exp_count != 0))
        else fail_and_stop("output beat delivered with none outstanding");

    a_hold : assert property (@(posedge aclk) disable iff (!rst_n)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(act_beat)))
        else fail_and_stop("stalled output beat changed or was dropped");

    // Ready stays high up to DEPTH beats, then stays low
    a_fill : assert property (@(posedge aclk) disable iff (!rst_n)
        fill_phase |-> ((fill_cnt < DEPTH && in_tready) || (fill_cnt == DEPTH && !in_tready)))
        else fail_and_stop("in_tready does not match the number of beats held");

    a_ready_back : assert property (@(posedge aclk) disable iff (!rst_n)
        (pop_phase && out_tvalid && out_tready) |=> in_tready)
        else fail_and_stop("in_tready did not return after a pop from full");

    a_first_lat : assert property (@(posedge aclk) disable iff (!rst_n)
        (lat_phase && lat_cnt != 0 && lat_cnt <= FIRST_LAT)
            |-> (out_tvalid == (lat_cnt == FIRST_LAT)))
        else fail_and_stop("first beat appeared at the wrong edge");

    a_idle : assert property (@(posedge aclk) disable iff (!rst_n)
        drain_phase |-> (!out_tvalid && in_tready && exp_count == 0))
        else fail_and_stop("FIFO not idle after draining");

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int sent;
        int iter;
        int k;
        rst_n      = 1'b1;
        in_tvalid  = 1'b0;
        in_tdata   = '0;
        in_tkeep   = '0;
        in_tlast   = 1'b0;
        in_tid     = '0;
        in_tdest   = '0;
        in_tuser   = '0;
        out_tready = 1'b0;
        // Falling edge so the async reset fires
        #1 rst_n = 1'b0;
        repeat (10) @(posedge aclk);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge aclk);
        #1;

        // Single beats into an empty FIFO
        test_name  = "first_beat";
        lat_phase  = 1'b1;
        out_tready = 1'b1;
        for (k = 0; k < 4; k++) begin
            drive_random_beat();
            in_tvalid = 1'b1;
            wait_in_accept(50);
            in_tvalid = 1'b0;
            wait_drained(50);
        end
        lat_phase = 1'b0;

        // Random valid gaps and random back-pressure
        test_name = "random_stream";
        sent      = 0;
        iter      = 0;
        while (sent < NUM_BEATS) begin
            @(posedge aclk);
            #1;
            iter++;
            if (iter > NUM_BEATS * 20) fail_and_stop("timeout in the random stream");
            if (in_fire_q) sent++;
            // Valid may only drop after a transfer
            if (!in_tvalid || in_fire_q) begin
                if (sent < NUM_BEATS && (next_rand() & 32'h3) != 32'h0) begin
                    drive_random_beat();
                    in_tvalid = 1'b1;
                end else begin
                    in_tvalid = 1'b0;
                end
            end
            out_tready = ((next_rand() % 3) != 32'h0);
        end

        test_name  = "drain";
        out_tready = 1'b1;
        wait_drained(DEPTH * 8);
        drain_phase = 1'b1;
        repeat (10) @(posedge aclk);
        #1 drain_phase = 1'b0;

        // Fill to DEPTH with the output stalled
        test_name  = "full_flag";
        out_tready = 1'b0;
        drive_random_beat();
        in_tvalid  = 1'b1;
        fill_phase = 1'b1;
        iter       = 0;
        do begin
            @(posedge aclk);
            #1;
            iter++;
            if (iter > DEPTH * 4) fail_and_stop("timeout waiting for in_tready to fall");
            if (in_fire_q) drive_random_beat();
        end while (in_tready);
        repeat (5) @(posedge aclk);
        #1;

        // One pop, then the waiting beat goes in
        fill_phase = 1'b0;
        pop_phase  = 1'b1;
        out_tready = 1'b1;
        wait_out_accept(10);
        out_tready = 1'b0;
        wait_in_accept(10);
        in_tvalid  = 1'b0;
        pop_phase  = 1'b0;

        test_name  = "final_drain";
        out_tready = 1'b1;
        wait_drained(DEPTH * 8);
        drain_phase = 1'b1;
        repeat (10) @(posedge aclk);
        #1 drain_phase = 1'b0;

        $display("Finished with no errors");
        $finish;
    end

    // Whole-run limit
    initial begin
        repeat (100000) @(posedge aclk);
        fail_and_stop("simulation watchdog expired");
    end

endmodule : tb_axi4s_fifo_sync

/* verilog.f */
common/axi4s_pkg.sv
fifo/fifo_ctrl.sv
fifo/fifo_ram.sv
fifo/axi4s_fifo_core.sv
hdl/axi4s_fifo_sync.sv
sim/tb_axi4s_fifo_sync.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AXI-S FIFO testbench with Verilator in both modes
# Mode 0 is timing mode, mode 1 is latency mode
set -e

cd "$(dirname "$0")"

for mode in 0 1; do
    obj="obj_dir_mode${mode}"
    log="sim_mode${mode}.log"

    verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_axi4s_fifo_sync -GFIFO_OPT_MODE=${mode} \
        -f verilog.f --Mdir "${obj}" -o Vtb

    # The log decides the result, not the exit code
    "./${obj}/Vtb" > "${log}" 2>&1 || true
    cat "${log}"

    if ! grep -qx "Finished with no errors" "${log}"; then
        echo "Simulation failed in mode ${mode}"
        exit 1
    fi
done

echo "Both modes passed"
